// ==== dtw_accel.f ====
hw/dtw_pkg.sv
hw/axi_lite_slave.sv
hw/dtw_regs.sv
hw/stream_fifo.sv
hw/frame_forwarder.sv
hw/dtw_accel.sv
tb/dtw_accel_sva.sv
tb/tb_dtw_accel.sv

// ==== hw/axi_lite_slave.sv ====
// One transaction at a time, writes win over reads. The register side
// must acknowledge every strobe, otherwise the bus stalls.
`timescale 1ns/1ps

module axi_lite_slave import dtw_pkg::*; (
    input  logic      S_AXI_clk,
    input  logic      w_axi_rst,

    input  logic      i_axi_awvalid,
    input  axi_addr_t i_axi_awaddr,
    output logic      o_axi_awready,

    input  logic      i_axi_wvalid,
    input  axi_data_t i_axi_wdata,
    output logic      o_axi_wready,

    output logic      o_axi_bvalid,
    input  logic      i_axi_bready,
    output axi_resp_t o_axi_bresp,

    input  logic      i_axi_arvalid,
    input  axi_addr_t i_axi_araddr,
    output logic      o_axi_arready,

    output logic      o_axi_rvalid,
    input  logic      i_axi_rready,
    output axi_resp_t o_axi_rresp,
    output axi_data_t o_axi_rdata,

    output logic      o_reg_wr_stb,
    output logic      o_reg_rd_stb,
    output reg_idx_t  o_reg_addr,
    output axi_data_t o_reg_wdata,
    input  logic      i_reg_ack,
    input  axi_data_t i_reg_rdata,
    input  logic      i_reg_invalid
);

    // Word index sits above the byte offset
    localparam int IDX_LSB = 2;

    axi_state_e r_state;
    logic       r_is_write;
    axi_resp_t  r_resp;
    axi_data_t  r_rdata;
    logic       w_wr_hs;
    logic       w_rd_hs;

    // Address and data channels must both be valid to take a write
    assign w_wr_hs = (r_state == AXI_IDLE) && i_axi_awvalid && i_axi_wvalid;
    assign w_rd_hs = (r_state == AXI_IDLE) && i_axi_arvalid && !(i_axi_awvalid && i_axi_wvalid);

    assign o_axi_awready = w_wr_hs;
    assign o_axi_wready  = w_wr_hs;
    assign o_axi_arready = w_rd_hs;

    assign o_reg_wr_stb = (r_state == AXI_STROBE) && r_is_write;
    assign o_reg_rd_stb = (r_state == AXI_STROBE) && !r_is_write;

    assign o_axi_bvalid = (r_state == AXI_RESP) && r_is_write;
    assign o_axi_rvalid = (r_state == AXI_RESP) && !r_is_write;
    assign o_axi_bresp  = r_resp;
    assign o_axi_rresp  = r_resp;
    assign o_axi_rdata  = r_rdata;

    always_ff @(posedge S_AXI_clk) begin
        if (w_axi_rst) begin
            r_state    <= AXI_IDLE;
            r_is_write <= 1'b0;
        end else begin
            case (r_state)
                AXI_IDLE: begin
                    if (w_wr_hs) begin
                        r_is_write <= 1'b1;
                        r_state    <= AXI_STROBE;
                    end else if (w_rd_hs) begin
                        r_is_write <= 1'b0;
                        r_state    <= AXI_STROBE;
                    end
                end
                AXI_STROBE: begin
                    r_state <= AXI_WAIT_ACK;
                end
                AXI_WAIT_ACK: begin
                    if (i_reg_ack) begin
                        r_state <= AXI_RESP;
                    end
                end
                AXI_RESP: begin
                    // Hold the response until the master takes it
                    if (r_is_write ? i_axi_bready : i_axi_rready) begin
                        r_state <= AXI_IDLE;
                    end
                end
                default: begin
                    r_state <= AXI_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge S_AXI_clk) begin
        if (w_wr_hs) begin
            o_reg_addr  <= i_axi_awaddr[IDX_LSB +: $bits(reg_idx_t)];
            o_reg_wdata <= i_axi_wdata;
        end else if (w_rd_hs) begin
            o_reg_addr <= i_axi_araddr[IDX_LSB +: $bits(reg_idx_t)];
        end

        if ((r_state == AXI_WAIT_ACK) && i_reg_ack) begin
            r_resp  <= i_reg_invalid ? RESP_SLVERR : RESP_OKAY;
            r_rdata <= i_reg_rdata;
        end
    end

endmodule

// ==== hw/dtw_accel.sv ====
// Control shell on one clock. Stream ready/valid come straight from the
// FIFO flags; the sink FIFO carries tlast in its top bit.
`timescale 1ns/1ps

module dtw_accel import dtw_pkg::*; #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic      S_AXI_clk,
    input  logic      w_axi_rst,

    input  logic      i_axi_awvalid,
    input  axi_addr_t i_axi_awaddr,
    output logic      o_axi_awready,
    input  logic      i_axi_wvalid,
    input  axi_data_t i_axi_wdata,
    output logic      o_axi_wready,
    output logic      o_axi_bvalid,
    input  logic      i_axi_bready,
    output axi_resp_t o_axi_bresp,
    input  logic      i_axi_arvalid,
    input  axi_addr_t i_axi_araddr,
    output logic      o_axi_arready,
    output logic      o_axi_rvalid,
    input  logic      i_axi_rready,
    output axi_resp_t o_axi_rresp,
    output axi_data_t o_axi_rdata,

    input  logic      i_src_tvalid,
    output logic      o_src_tready,
    input  sample_t   i_src_tdata,

    output logic      o_sink_tvalid,
    input  logic      i_sink_tready,
    output logic      o_sink_tlast,
    output sample_t   o_sink_tdata
);

    logic      w_reg_wr_stb;
    logic      w_reg_rd_stb;
    reg_idx_t  w_reg_addr;
    axi_data_t w_reg_wdata;
    logic      w_reg_ack;
    axi_data_t w_reg_rdata;
    logic      w_reg_invalid;

    logic      w_core_rst;
    logic      w_run;
    ref_len_t  w_ref_len;
    logic      w_busy;
    axi_data_t w_nquery;

    logic      w_src_full;
    logic      w_src_empty;
    logic      w_src_rd_stb;
    sample_t   w_src_data;
    logic      w_sink_full;
    logic      w_sink_empty;
    logic      w_sink_wr_stb;
    sample_t   w_sink_data;
    logic      w_sink_last;
    logic      w_src_push;
    logic      w_sink_pop;

    // Stream handshakes
    assign o_src_tready  = ~w_src_full;
    assign o_sink_tvalid = ~w_sink_empty;
    assign w_src_push    = i_src_tvalid & o_src_tready;
    assign w_sink_pop    = o_sink_tvalid & i_sink_tready;

    axi_lite_slave u_axi_lite_slave (
        .S_AXI_clk     (S_AXI_clk),
        .w_axi_rst     (w_axi_rst),
        .i_axi_awvalid (i_axi_awvalid),
        .i_axi_awaddr  (i_axi_awaddr),
        .o_axi_awready (o_axi_awready),
        .i_axi_wvalid  (i_axi_wvalid),
        .i_axi_wdata   (i_axi_wdata),
        .o_axi_wready  (o_axi_wready),
        .o_axi_bvalid  (o_axi_bvalid),
        .i_axi_bready  (i_axi_bready),
        .o_axi_bresp   (o_axi_bresp),
        .i_axi_arvalid (i_axi_arvalid),
        .i_axi_araddr  (i_axi_araddr),
        .o_axi_arready (o_axi_arready),
        .o_axi_rvalid  (o_axi_rvalid),
        .i_axi_rready  (i_axi_rready),
        .o_axi_rresp   (o_axi_rresp),
        .o_axi_rdata   (o_axi_rdata),
        .o_reg_wr_stb  (w_reg_wr_stb),
        .o_reg_rd_stb  (w_reg_rd_stb),
        .o_reg_addr    (w_reg_addr),
        .o_reg_wdata   (w_reg_wdata),
        .i_reg_ack     (w_reg_ack),
        .i_reg_rdata   (w_reg_rdata),
        .i_reg_invalid (w_reg_invalid)
    );

    dtw_regs u_dtw_regs (
        .S_AXI_clk     (S_AXI_clk),
        .w_axi_rst     (w_axi_rst),
        .i_reg_wr_stb  (w_reg_wr_stb),
        .i_reg_rd_stb  (w_reg_rd_stb),
        .i_reg_addr    (w_reg_addr),
        .i_reg_wdata   (w_reg_wdata),
        .o_reg_ack     (w_reg_ack),
        .o_reg_rdata   (w_reg_rdata),
        .o_reg_invalid (w_reg_invalid),
        .i_busy        (w_busy),
        .i_nquery      (w_nquery),
        .i_src_empty   (w_src_empty),
        .i_src_full    (w_src_full),
        .i_sink_empty  (w_sink_empty),
        .i_sink_full   (w_sink_full),
        .o_core_rst    (w_core_rst),
        .o_run         (w_run),
        .o_ref_len     (w_ref_len)
    );

    // Core reset also flushes pending source samples
    stream_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .WIDTH      ($bits(sample_t))
    ) u_src_fifo (
        .S_AXI_clk (S_AXI_clk),
        .w_axi_rst (w_axi_rst),
        .i_clear   (w_core_rst),
        .i_wr_stb  (w_src_push),
        .i_wr_data (i_src_tdata),
        .i_rd_stb  (w_src_rd_stb),
        .o_rd_data (w_src_data),
        .o_full    (w_src_full),
        .o_empty   (w_src_empty)
    );

    frame_forwarder u_frame_forwarder (
        .S_AXI_clk     (S_AXI_clk),
        .w_axi_rst     (w_axi_rst),
        .i_core_rst    (w_core_rst),
        .i_run         (w_run),
        .i_ref_len     (w_ref_len),
        .i_src_empty   (w_src_empty),
        .i_src_data    (w_src_data),
        .o_src_rd_stb  (w_src_rd_stb),
        .i_sink_full   (w_sink_full),
        .o_sink_wr_stb (w_sink_wr_stb),
        .o_sink_data   (w_sink_data),
        .o_sink_last   (w_sink_last),
        .o_busy        (w_busy),
        .o_nquery      (w_nquery)
    );

    stream_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .WIDTH      ($bits(sample_t) + 1)
    ) u_sink_fifo (
        .S_AXI_clk (S_AXI_clk),
        .w_axi_rst (w_axi_rst),
        .i_clear   (1'b0),
        .i_wr_stb  (w_sink_wr_stb),
        .i_wr_data ({w_sink_last, w_sink_data}),
        .i_rd_stb  (w_sink_pop),
        .o_rd_data ({o_sink_tlast, o_sink_tdata}),
        .o_full    (w_sink_full),
        .o_empty   (w_sink_empty)
    );

endmodule

// ==== hw/dtw_pkg.sv ====
// Shared types and register map of the accelerator control shell.
// Register indices are word indices; the byte address is the index times 4.
package dtw_pkg;

    // Bus and stream widths
    typedef logic [15:0] axi_addr_t;
    typedef logic [31:0] axi_data_t;
    typedef logic [31:0] sample_t;
    typedef logic [31:0] ref_len_t;
    typedef logic [3:0]  reg_idx_t;
    typedef logic [1:0]  axi_resp_t;

    // Register map
    localparam reg_idx_t REG_CONTROL = 4'd0;
    localparam reg_idx_t REG_STATUS  = 4'd1;
    localparam reg_idx_t REG_REF_LEN = 4'd2;
    localparam reg_idx_t REG_VERSION = 4'd3;
    localparam reg_idx_t REG_KEY     = 4'd4;
    localparam reg_idx_t REG_NQUERY  = 4'd5;

    localparam axi_resp_t RESP_OKAY   = 2'b00;
    localparam axi_resp_t RESP_SLVERR = 2'b10;

    // Version fields, packed as major[31:28], minor[27:20], rev[19:16]
    localparam logic [3:0] VERSION_MAJOR = 4'd0;
    localparam logic [7:0] VERSION_MINOR = 8'd0;
    localparam logic [3:0] VERSION_REV   = 4'd2;
    localparam axi_data_t  VERSION_WORD  = {VERSION_MAJOR, VERSION_MINOR, VERSION_REV, 16'h0000};

    localparam axi_data_t ACCEL_KEY = 32'h0CA7_CAFE;

    // Control bits
    localparam int CTRL_CORE_RST_BIT = 0;
    localparam int CTRL_RUN_BIT      = 1;

    // Status bits, all others read zero
    localparam int STAT_BUSY_BIT       = 0;
    localparam int STAT_SRC_EMPTY_BIT  = 1;
    localparam int STAT_SRC_FULL_BIT   = 2;
    localparam int STAT_SINK_EMPTY_BIT = 3;
    localparam int STAT_SINK_FULL_BIT  = 4;

    typedef enum logic [1:0] {
        AXI_IDLE,
        AXI_STROBE,
        AXI_WAIT_ACK,
        AXI_RESP
    } axi_state_e;

endpackage

// ==== hw/dtw_regs.sv ====
// Acks every strobe one cycle later. Indices above REG_NQUERY are invalid;
// writes to read-only registers are dropped without error.
`timescale 1ns/1ps

module dtw_regs import dtw_pkg::*; (
    input  logic      S_AXI_clk,
    input  logic      w_axi_rst,

    input  logic      i_reg_wr_stb,
    input  logic      i_reg_rd_stb,
    input  reg_idx_t  i_reg_addr,
    input  axi_data_t i_reg_wdata,
    output logic      o_reg_ack,
    output axi_data_t o_reg_rdata,
    output logic      o_reg_invalid,

    input  logic      i_busy,
    input  axi_data_t i_nquery,
    input  logic      i_src_empty,
    input  logic      i_src_full,
    input  logic      i_sink_empty,
    input  logic      i_sink_full,

    output logic      o_core_rst,
    output logic      o_run,
    output ref_len_t  o_ref_len
);

    localparam ref_len_t REF_LEN_DEFAULT = 32'd4;

    axi_data_t r_control;
    ref_len_t  r_ref_len;
    axi_data_t w_status;
    axi_data_t w_rd_word;

    assign o_core_rst = r_control[CTRL_CORE_RST_BIT];
    assign o_run      = r_control[CTRL_RUN_BIT];
    assign o_ref_len  = r_ref_len;

    always_comb begin
        w_status                      = '0;
        w_status[STAT_BUSY_BIT]       = i_busy;
        w_status[STAT_SRC_EMPTY_BIT]  = i_src_empty;
        w_status[STAT_SRC_FULL_BIT]   = i_src_full;
        w_status[STAT_SINK_EMPTY_BIT] = i_sink_empty;
        w_status[STAT_SINK_FULL_BIT]  = i_sink_full;
    end

    // Read-back mux, zero for unknown indices
    always_comb begin
        case (i_reg_addr)
            REG_CONTROL: w_rd_word = r_control;
            REG_STATUS:  w_rd_word = w_status;
            REG_REF_LEN: w_rd_word = r_ref_len;
            REG_VERSION: w_rd_word = VERSION_WORD;
            REG_KEY:     w_rd_word = ACCEL_KEY;
            REG_NQUERY:  w_rd_word = i_nquery;
            default:     w_rd_word = '0;
        endcase
    end

    always_ff @(posedge S_AXI_clk) begin
        if (w_axi_rst) begin
            o_reg_ack     <= 1'b0;
            o_reg_invalid <= 1'b0;
            r_control     <= '0;
            r_ref_len     <= REF_LEN_DEFAULT;
        end else begin
            o_reg_ack     <= i_reg_wr_stb || i_reg_rd_stb;
            o_reg_invalid <= (i_reg_wr_stb || i_reg_rd_stb) && (i_reg_addr > REG_NQUERY);
            if (i_reg_wr_stb) begin
                case (i_reg_addr)
                    REG_CONTROL: r_control <= i_reg_wdata;
                    REG_REF_LEN: r_ref_len <= i_reg_wdata;
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge S_AXI_clk) begin
        if (i_reg_rd_stb) begin
            o_reg_rdata <= w_rd_word;
        end
    end

endmodule

// ==== hw/frame_forwarder.sv ====
// Stands in for the warping core; one sample per cycle while running.
// A reference length of zero behaves as a length of one.
`timescale 1ns/1ps

module frame_forwarder import dtw_pkg::*; (
    input  logic      S_AXI_clk,
    input  logic      w_axi_rst,
    input  logic      i_core_rst,
    input  logic      i_run,
    input  ref_len_t  i_ref_len,

    input  logic      i_src_empty,
    input  sample_t   i_src_data,
    output logic      o_src_rd_stb,

    input  logic      i_sink_full,
    output logic      o_sink_wr_stb,
    output sample_t   o_sink_data,
    output logic      o_sink_last,

    output logic      o_busy,
    output axi_data_t o_nquery
);

    ref_len_t  r_sample_cnt;
    axi_data_t r_nquery;
    ref_len_t  w_last_idx;
    logic      w_at_end;
    logic      w_move;

    assign w_last_idx = (i_ref_len == '0) ? '0 : i_ref_len - 1'b1;

    // Also wraps if the length shrinks below the current count mid-frame
    assign w_at_end = (r_sample_cnt >= w_last_idx);

    // Pop and push together, never while the core is held in reset
    assign w_move = i_run && !i_core_rst && !i_src_empty && !i_sink_full;

    assign o_src_rd_stb  = w_move;
    assign o_sink_wr_stb = w_move;
    assign o_sink_data   = i_src_data;
    assign o_sink_last   = w_at_end;
    assign o_busy        = (r_sample_cnt != '0);
    assign o_nquery      = r_nquery;

    always_ff @(posedge S_AXI_clk) begin
        if (w_axi_rst || i_core_rst) begin
            r_sample_cnt <= '0;
            r_nquery     <= '0;
        end else if (w_move) begin
            if (w_at_end) begin
                r_sample_cnt <= '0;
                r_nquery     <= r_nquery + 1'b1;
            end else begin
                r_sample_cnt <= r_sample_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== hw/stream_fifo.sv ====
// Show-ahead FIFO, FIFO_DEPTH must be a power of two and at least 2.
// Head word reads zero while empty.
`timescale 1ns/1ps

module stream_fifo #(
    parameter int FIFO_DEPTH = 4,
    parameter int WIDTH      = 32
) (
    input  logic             S_AXI_clk,
    input  logic             w_axi_rst,
    input  logic             i_clear,
    input  logic             i_wr_stb,
    input  logic [WIDTH-1:0] i_wr_data,
    input  logic             i_rd_stb,
    output logic [WIDTH-1:0] o_rd_data,
    output logic             o_full,
    output logic             o_empty
);

    localparam int             PTR_W      = $clog2(FIFO_DEPTH);
    localparam logic [PTR_W:0] FULL_COUNT = FIFO_DEPTH[PTR_W:0];

    logic [WIDTH-1:0] r_mem [FIFO_DEPTH];
    logic [PTR_W-1:0] r_wr_ptr;
    logic [PTR_W-1:0] r_rd_ptr;
    logic [PTR_W:0]   r_count;
    logic             w_push;
    logic             w_pop;

    assign o_full    = (r_count == FULL_COUNT);
    assign o_empty   = (r_count == '0);
    assign o_rd_data = o_empty ? '0 : r_mem[r_rd_ptr];

    // Overflow and underflow requests are dropped here
    assign w_push = i_wr_stb && !o_full;
    assign w_pop  = i_rd_stb && !o_empty;

    always_ff @(posedge S_AXI_clk) begin
        if (w_axi_rst || i_clear) begin
            r_wr_ptr <= '0;
            r_rd_ptr <= '0;
            r_count  <= '0;
        end else begin
            if (w_push) begin
                r_wr_ptr <= r_wr_ptr + 1'b1;
            end
            if (w_pop) begin
                r_rd_ptr <= r_rd_ptr + 1'b1;
            end
            case ({w_push, w_pop})
                2'b10:   r_count <= r_count + 1'b1;
                2'b01:   r_count <= r_count - 1'b1;
                default: r_count <= r_count;
            endcase
        end
    end

    always_ff @(posedge S_AXI_clk) begin
        if (w_push) begin
            r_mem[r_wr_ptr] <= i_wr_data;
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_dtw_accel -o Vtb_dtw_accel -f dtw_accel.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_dtw_accel)
sim_status=$?
printf '%s\n' "$sim_out"

if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "sim passed"; then
    exit 0
fi
echo "Pass line not found in simulation output"
exit 1

// ==== tb/dtw_accel_sva.sv ====
// Protocol checks on the AXI response channels and the sink stream.
// Bound into every dtw_accel instance.
`timescale 1ns/1ps

module dtw_accel_sva import dtw_pkg::*; (
    input logic      S_AXI_clk,
    input logic      w_axi_rst,
    input logic      o_axi_bvalid,
    input logic      i_axi_bready,
    input axi_resp_t o_axi_bresp,
    input logic      o_axi_rvalid,
    input logic      i_axi_rready,
    input axi_resp_t o_axi_rresp,
    input axi_data_t o_axi_rdata,
    input logic      o_sink_tvalid,
    input logic      i_sink_tready,
    input logic      o_sink_tlast,
    input sample_t   o_sink_tdata
);

    int fail_count = 0;

    // Write response held until taken
    a_bvalid_hold: assert property (@(posedge S_AXI_clk) disable iff (w_axi_rst)
        o_axi_bvalid && !i_axi_bready |=> o_axi_bvalid && $stable(o_axi_bresp))
        else begin
            fail_count++;
            $error("bvalid dropped or bresp changed before bready");
        end

    // Read data held until taken
    a_rvalid_hold: assert property (@(posedge S_AXI_clk) disable iff (w_axi_rst)
        o_axi_rvalid && !i_axi_rready |=>
            o_axi_rvalid && $stable(o_axi_rresp) && $stable(o_axi_rdata))
        else begin
            fail_count++;
            $error("rvalid dropped or read data changed before rready");
        end

    a_sink_hold: assert property (@(posedge S_AXI_clk) disable iff (w_axi_rst)
        o_sink_tvalid && !i_sink_tready |=>
            o_sink_tvalid && $stable(o_sink_tdata) && $stable(o_sink_tlast))
        else begin
            fail_count++;
            $error("sink tvalid dropped or payload changed before tready");
        end

    // Nothing leaves the design while reset is applied
    a_reset_quiet: assert property (@(posedge S_AXI_clk)
        w_axi_rst |=> !o_sink_tvalid && !o_axi_bvalid)
        else begin
            fail_count++;
            $error("tvalid or bvalid high during reset");
        end

endmodule

bind dtw_accel dtw_accel_sva u_dtw_accel_sva (
    .S_AXI_clk     (S_AXI_clk),
    .w_axi_rst     (w_axi_rst),
    .o_axi_bvalid  (o_axi_bvalid),
    .i_axi_bready  (i_axi_bready),
    .o_axi_bresp   (o_axi_bresp),
    .o_axi_rvalid  (o_axi_rvalid),
    .i_axi_rready  (i_axi_rready),
    .o_axi_rresp   (o_axi_rresp),
    .o_axi_rdata   (o_axi_rdata),
    .o_sink_tvalid (o_sink_tvalid),
    .i_sink_tready (i_sink_tready),
    .o_sink_tlast  (o_sink_tlast),
    .o_sink_tdata  (o_sink_tdata)
);

// ==== tb/tb_dtw_accel.sv ====
// Register checks and a framed random stream against a reference model.
// Inputs change on the falling edge; DUT outputs are sampled on the rising edge.
`timescale 1ns/1ps

module tb_dtw_accel import dtw_pkg::*; ();

    localparam int          CLK_HALF      = 2;
    localparam int          RST_CYCLES    = 10;
    localparam int          TIMEOUT       = 200;
    localparam int          DRAIN_TIMEOUT = 1000;
    localparam int          FRAME_LEN     = 5;
    localparam int          NUM_SAMPLES   = 15;
    localparam logic [31:0] LFSR_SEED     = 32'hc4f0_8be0;
    // x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] LFSR_TAPS     = 32'h8020_0003;
    localparam axi_data_t   EXP_VERSION   = 32'h0002_0000;
    localparam axi_data_t   EXP_KEY       = 32'h0CA7_CAFE;

    logic      S_AXI_clk = 1'b0;
    logic      w_axi_rst;
    logic      i_axi_awvalid;
    axi_addr_t i_axi_awaddr;
    logic      o_axi_awready;
    logic      i_axi_wvalid;
    axi_data_t i_axi_wdata;
    logic      o_axi_wready;
    logic      o_axi_bvalid;
    logic      i_axi_bready;
    axi_resp_t o_axi_bresp;
    logic      i_axi_arvalid;
    axi_addr_t i_axi_araddr;
    logic      o_axi_arready;
    logic      o_axi_rvalid;
    logic      i_axi_rready;
    axi_resp_t o_axi_rresp;
    axi_data_t o_axi_rdata;
    logic      i_src_tvalid;
    logic      o_src_tready;
    sample_t   i_src_tdata;
    logic      o_sink_tvalid;
    logic      i_sink_tready = 1'b0;
    logic      o_sink_tlast;
    sample_t   o_sink_tdata;

    sample_t     sent_q[$];
    int          out_idx = 0;
    int          ref_len_model = FRAME_LEN;
    logic [31:0] lfsr_data = LFSR_SEED;
    logic [31:0] lfsr_ready = LFSR_SEED;

    dtw_accel #(.FIFO_DEPTH(4)) u_dtw_accel (.*);

    always #CLK_HALF S_AXI_clk = ~S_AXI_clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);
    endfunction

    // Expected {tlast, tdata} of output beat idx
    function automatic logic [32:0] expected_beat(input int idx, input int frame_len);
        int   len;
        logic last;
        len  = (frame_len < 1) ? 1 : frame_len;
        last = ((idx + 1) % len) == 0;
        return {last, sent_q[idx]};
    endfunction

    function automatic axi_data_t status_word(input logic busy, input logic src_empty,
                                              input logic src_full, input logic sink_empty,
                                              input logic sink_full);
        axi_data_t w;
        w                      = '0;
        w[STAT_BUSY_BIT]       = busy;
        w[STAT_SRC_EMPTY_BIT]  = src_empty;
        w[STAT_SRC_FULL_BIT]   = src_full;
        w[STAT_SINK_EMPTY_BIT] = sink_empty;
        w[STAT_SINK_FULL_BIT]  = sink_full;
        return w;
    endfunction

    function automatic axi_addr_t reg_addr(input reg_idx_t idx);
        return axi_addr_t'(idx) << 2;
    endfunction

    task automatic stop_on_failure(input string reason);
        $display("ERROR: %s", reason);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            $display("[ERROR] %s: expected 0x%08h, actual 0x%08h", name, exp, act);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    task automatic draw_sample(output sample_t s);
        for (int b = 0; b < $bits(sample_t); b++) begin
            lfsr_data = lfsr_next(lfsr_data);
            s[b]      = lfsr_data[0];
        end
    endtask

    task automatic axi_write(input axi_addr_t addr, input axi_data_t data,
                             output axi_resp_t resp);
        int n;
        @(negedge S_AXI_clk);
        i_axi_awvalid = 1'b1;
        i_axi_awaddr  = addr;
        i_axi_wvalid  = 1'b1;
        i_axi_wdata   = data;
        n = 0;
        @(posedge S_AXI_clk);
        while (!o_axi_awready) begin
            n++;
            assert (n < TIMEOUT) else stop_on_failure("timeout on write address handshake");
            @(posedge S_AXI_clk);
        end
        check_value("write data ready", 32'd1, o_axi_wready);
        @(negedge S_AXI_clk);
        i_axi_awvalid = 1'b0;
        i_axi_wvalid  = 1'b0;
        n = 0;
        @(posedge S_AXI_clk);
        while (!o_axi_bvalid) begin
            n++;
            assert (n < TIMEOUT) else stop_on_failure("timeout waiting for write response");
            @(posedge S_AXI_clk);
        end
        // Response waits a cycle before the master takes it
        @(negedge S_AXI_clk);
        i_axi_bready = 1'b1;
        @(posedge S_AXI_clk);
        resp = o_axi_bresp;
        @(negedge S_AXI_clk);
        i_axi_bready = 1'b0;
    endtask

    task automatic axi_read(input axi_addr_t addr, output axi_data_t data,
                            output axi_resp_t resp);
        int n;
        @(negedge S_AXI_clk);
        i_axi_arvalid = 1'b1;
        i_axi_araddr  = addr;
        n = 0;
        @(posedge S_AXI_clk);
        while (!o_axi_arready) begin
            n++;
            assert (n < TIMEOUT) else stop_on_failure("timeout on read address handshake");
            @(posedge S_AXI_clk);
        end
        @(negedge S_AXI_clk);
        i_axi_arvalid = 1'b0;
        n = 0;
        @(posedge S_AXI_clk);
        while (!o_axi_rvalid) begin
            n++;
            assert (n < TIMEOUT) else stop_on_failure("timeout waiting for read data");
            @(posedge S_AXI_clk);
        end
        // Read data waits a cycle before the master takes it
        @(negedge S_AXI_clk);
        i_axi_rready = 1'b1;
        @(posedge S_AXI_clk);
        data = o_axi_rdata;
        resp = o_axi_rresp;
        @(negedge S_AXI_clk);
        i_axi_rready = 1'b0;
    endtask

    task automatic write_okay(input string name, input reg_idx_t idx, input axi_data_t data);
        axi_resp_t resp;
        axi_write(reg_addr(idx), data, resp);
        check_value({name, " bresp"}, RESP_OKAY, resp);
    endtask

    task automatic read_expect(input string name, input reg_idx_t idx, input axi_data_t exp);
        axi_data_t data;
        axi_resp_t resp;
        axi_read(reg_addr(idx), data, resp);
        check_value({name, " rresp"}, RESP_OKAY, resp);
        check_value(name, exp, data);
    endtask

    task automatic send_sample(input sample_t data);
        int n;
        @(negedge S_AXI_clk);
        i_src_tvalid = 1'b1;
        i_src_tdata  = data;
        n = 0;
        @(posedge S_AXI_clk);
        while (!o_src_tready) begin
            n++;
            assert (n < TIMEOUT) else stop_on_failure("timeout waiting for source tready");
            @(posedge S_AXI_clk);
        end
        sent_q.push_back(data);
        @(negedge S_AXI_clk);
        i_src_tvalid = 1'b0;
    endtask

    // Random sink back-pressure, one LFSR step per cycle
    always @(negedge S_AXI_clk) begin
        if (w_axi_rst) begin
            i_sink_tready = 1'b0;
        end else begin
            lfsr_ready    = lfsr_next(lfsr_ready);
            i_sink_tready = lfsr_ready[0];
        end
    end

    // Bound protocol checker
    always @(negedge S_AXI_clk) begin
        assert (u_dtw_accel.u_dtw_accel_sva.fail_count == 0)
            else stop_on_failure("a bound protocol assertion failed");
    end

    // Every sink handshake against the reference
    always @(posedge S_AXI_clk) begin
        logic [32:0] exp_beat;
        if (!w_axi_rst && o_sink_tvalid && i_sink_tready) begin
            assert (out_idx < sent_q.size())
                else stop_on_failure("sink produced more samples than were sent");
            exp_beat = expected_beat(out_idx, ref_len_model);
            check_value($sformatf("sink tdata %0d", out_idx), exp_beat[31:0], o_sink_tdata);
            check_value($sformatf("sink tlast %0d", out_idx), exp_beat[32], o_sink_tlast);
            out_idx++;
        end
    end

    initial begin
        axi_data_t data;
        axi_resp_t resp;
        sample_t   smp;
        int        n;
        w_axi_rst     = 1'b1;
        i_axi_awvalid = 1'b0;
        i_axi_awaddr  = '0;
        i_axi_wvalid  = 1'b0;
        i_axi_wdata   = '0;
        i_axi_bready  = 1'b0;
        i_axi_arvalid = 1'b0;
        i_axi_araddr  = '0;
        i_axi_rready  = 1'b0;
        i_src_tvalid  = 1'b0;
        i_src_tdata   = '0;
        repeat (RST_CYCLES) @(posedge S_AXI_clk);
        @(negedge S_AXI_clk);
        w_axi_rst = 1'b0;

        // Reset values
        read_expect("version", REG_VERSION, EXP_VERSION);
        read_expect("key", REG_KEY, EXP_KEY);
        read_expect("control after reset", REG_CONTROL, 32'd0);
        read_expect("query count after reset", REG_NQUERY, 32'd0);
        read_expect("ref length after reset", REG_REF_LEN, 32'd4);
        read_expect("status after reset", REG_STATUS, status_word(0, 1, 0, 1, 0));

        // Read-back, and the key is read-only
        write_okay("ref length write", REG_REF_LEN, 32'd7);
        read_expect("ref length readback", REG_REF_LEN, 32'd7);
        write_okay("control write", REG_CONTROL, 32'd1 << CTRL_RUN_BIT);
        read_expect("control readback", REG_CONTROL, 32'd1 << CTRL_RUN_BIT);
        write_okay("control clear", REG_CONTROL, 32'd0);
        write_okay("key write", REG_KEY, 32'h1234_5678);
        read_expect("key after write", REG_KEY, EXP_KEY);

        // Index 9 is outside the map
        axi_write(reg_addr(4'd9), 32'hdead_beef, resp);
        check_value("invalid index bresp", RESP_SLVERR, resp);
        axi_read(reg_addr(4'd9), data, resp);
        check_value("invalid index rresp", RESP_SLVERR, resp);
        check_value("invalid index rdata", 32'd0, data);

        // Framed stream under random back-pressure
        ref_len_model = FRAME_LEN;
        write_okay("frame length", REG_REF_LEN, FRAME_LEN);
        write_okay("run set", REG_CONTROL, 32'd1 << CTRL_RUN_BIT);
        for (int i = 0; i < NUM_SAMPLES; i++) begin
            draw_sample(smp);
            send_sample(smp);
        end
        n = 0;
        while (out_idx < NUM_SAMPLES) begin
            @(negedge S_AXI_clk);
            n++;
            assert (n < DRAIN_TIMEOUT) else stop_on_failure("timeout draining the sink stream");
        end
        read_expect("query count after stream", REG_NQUERY, NUM_SAMPLES / FRAME_LEN);
        read_expect("status after drain", REG_STATUS, status_word(0, 1, 0, 1, 0));

        // Run cleared, samples stay in the source FIFO
        write_okay("run clear", REG_CONTROL, 32'd0);
        for (int i = 0; i < 2; i++) begin
            draw_sample(smp);
            send_sample(smp);
        end
        read_expect("status with run cleared", REG_STATUS, status_word(0, 0, 0, 1, 0));
        check_value("sink count with run cleared", NUM_SAMPLES, out_idx);

        // Core reset pulse
        write_okay("core reset set", REG_CONTROL, 32'd1 << CTRL_CORE_RST_BIT);
        write_okay("core reset clear", REG_CONTROL, 32'd0);
        read_expect("query count after core reset", REG_NQUERY, 32'd0);
        read_expect("status after core reset", REG_STATUS, status_word(0, 1, 0, 1, 0));
        check_value("sink count after core reset", NUM_SAMPLES, out_idx);

        if (u_dtw_accel.u_dtw_accel_sva.fail_count == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            stop_on_failure("a bound protocol assertion failed");
        end
    end

endmodule
